// File: io_bus_cfg.svh
// IO bus configuration: register addresses, reset values and timer count width
`ifndef IO_BUS_CFG_SVH
`define IO_BUS_CFG_SVH

// Register map on the 16-bit IO address bus
`define IO_ADDR_SCRATCH0 16'h0010   // General purpose scratch
`define IO_ADDR_SCRATCH1 16'h0011   // Scratch with non-zero reset pattern
`define IO_ADDR_TMR_CTRL 16'h0020   // Timer enable, clear, prescale
`define IO_ADDR_TMR_CNT  16'h0021   // Timer running count

// Register reset values
`define IO_RST_SCRATCH0  8'h00
`define IO_RST_SCRATCH1  8'hA5      // Easy to spot after reset
`define IO_RST_TMR_CTRL  8'h00      // Timer disabled, no clear
`define IO_RST_TMR_CNT   8'h00

// Timer count width, matches the 8-bit register data path
`define IO_TMR_CNT_W     8

`endif

// File: io_bus_pkg.sv
// IO bus package: bus master identifier and timer control byte layout
package io_bus_pkg;

   // Owner of a bus cycle
   typedef enum logic {
      MST_HOST  = 1'b0,
      MST_DEBUG = 1'b1
   } master_id_t;

   // Timer prescale field and counter
   typedef logic [5:0] tmr_presc_t;

   // Control byte seen as fields by the timer
   typedef struct packed {
      logic       enable;     // Bit 7, count while high
      logic       clear;      // Bit 6, force count to zero
      tmr_presc_t prescale;   // Bits 5:0, tick every prescale+1 cycles
   } tmr_ctrl_f_t;

   // Register stores the raw byte, timer decodes the fields
   typedef union packed {
      logic [7:0]  raw;
      tmr_ctrl_f_t f;
   } tmr_ctrl_u;

endpackage

// File: io_bus_if.sv
// IO bus interface: shared address, data and strobe lines between arbiter and registers
`timescale 1ns/1ps

interface io_bus_if;

   logic [15:0] addr;    // Target register address
   logic [7:0]  wdata;   // Write data
   logic        we_l;    // Write strobe, active low
   logic        re_l;    // Read strobe, active low
   logic [7:0]  rdata;   // OR of all register read data
   logic        rd_en;   // OR of all register read valids

   // Arbiter side
   modport master (
      output addr,
      output wdata,
      output we_l,
      output re_l,
      input  rdata,
      input  rd_en
   );

   // Register side, read data returns on separate per-register lines
   modport target (
      input addr,
      input wdata,
      input we_l,
      input re_l
   );

endinterface

// File: io_bus_arbiter.sv
// IO bus arbiter: round-robin between host and debug masters with read data return
`timescale 1ns/1ps

module io_bus_arbiter (
   input  logic        I_CLK,
   input  logic        I_SYNC_RESET,
   input  logic        host_req,
   input  logic        host_we,
   input  logic [15:0] host_addr,
   input  logic [7:0]  host_wdata,
   output logic        host_gnt,
   output logic        host_rvalid,
   output logic [7:0]  host_rdata,
   input  logic        debug_req,
   input  logic        debug_we,
   input  logic [15:0] debug_addr,
   input  logic [7:0]  debug_wdata,
   output logic        debug_gnt,
   output logic        debug_rvalid,
   output logic [7:0]  debug_rdata,
   io_bus_if.master    bus
);
   import io_bus_pkg::*;

   master_id_t  last_gnt;    // Winner of the previous grant
   master_id_t  win;         // Winner this cycle
   logic        host_elig;
   logic        debug_elig;
   logic        grant_any;
   logic        win_we;
   logic [15:0] win_addr;
   logic [7:0]  win_wdata;
   logic [1:0]  rd_vld;      // Read in flight, stage 0 then stage 1
   master_id_t  rd_own0;     // Owner of stage 0 read
   master_id_t  rd_own1;     // Owner of stage 1 read
   logic [7:0]  ret_data;

   // A request seen while its grant is still high is the one just served
   assign host_elig  = host_req & ~host_gnt;
   assign debug_elig = debug_req & ~debug_gnt;
   assign grant_any  = host_elig | debug_elig;

   always_comb begin
      if (host_elig & debug_elig) begin
         win = (last_gnt == MST_HOST) ? MST_DEBUG : MST_HOST;   // Loser of last round
      end else if (debug_elig) begin
         win = MST_DEBUG;
      end else begin
         win = MST_HOST;
      end
   end

   // Fields of the winning master
   assign win_we    = (win == MST_DEBUG) ? debug_we    : host_we;
   assign win_addr  = (win == MST_DEBUG) ? debug_addr  : host_addr;
   assign win_wdata = (win == MST_DEBUG) ? debug_wdata : host_wdata;

   // Unmapped read returns zero
   assign ret_data = bus.rd_en ? bus.rdata : 8'h00;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         host_gnt     <= 1'b0;
         debug_gnt    <= 1'b0;
         bus.we_l     <= 1'b1;
         bus.re_l     <= 1'b1;
         last_gnt     <= MST_DEBUG;   // Host wins the first tie
         rd_vld       <= 2'b00;
         host_rvalid  <= 1'b0;
         debug_rvalid <= 1'b0;
      end else begin
         host_gnt     <= grant_any & (win == MST_HOST);   // One-cycle pulse
         debug_gnt    <= grant_any & (win == MST_DEBUG);
         bus.we_l     <= ~(grant_any & win_we);
         bus.re_l     <= ~(grant_any & ~win_we);
         if (grant_any) begin
            last_gnt <= win;
         end
         rd_vld       <= {rd_vld[0], grant_any & ~win_we};   // Register answers at stage 1
         host_rvalid  <= rd_vld[1] & (rd_own1 == MST_HOST);
         debug_rvalid <= rd_vld[1] & (rd_own1 == MST_DEBUG);
      end
   end

   // Bus payload and read return path
   always_ff @(posedge I_CLK) begin
      if (grant_any) begin
         bus.addr  <= win_addr;
         bus.wdata <= win_wdata;
      end
      rd_own0 <= win;       // Qualified by rd_vld
      rd_own1 <= rd_own0;
      if (rd_vld[1] && (rd_own1 == MST_HOST)) begin
         host_rdata <= ret_data;
      end
      if (rd_vld[1] && (rd_own1 == MST_DEBUG)) begin
         debug_rdata <= ret_data;
      end
   end

endmodule

// File: io_bus_parser_reg.sv
// IO bus register: one memory-mapped 8-bit register with bus and external module sides
`timescale 1ns/1ps

module io_bus_parser_reg #(
   parameter logic [15:0] REG_ADDR = 16'h0000,   // Decoded bus address
   parameter logic [7:0]  RST_VAL  = 8'h00       // Value loaded on reset
) (
   input  logic       I_CLK,
   input  logic       I_SYNC_RESET,
   io_bus_if.target   bus,
   input  logic [7:0] data_wr,     // External write data
   input  logic       reg_wr_en,   // External write enable
   output logic [7:0] data_read,   // Current register value
   output logic       wait_wr,     // Bus write owns the register this cycle
   output logic [7:0] rdata,       // Bus read data, zero when idle
   output logic       rd_en        // Bus read data valid
);

   logic [7:0] io_reg;
   logic       hit;
   logic       bus_wr;
   logic       bus_rd;

   // Address decode and strobes
   assign hit    = (bus.addr == REG_ADDR);
   assign bus_wr = hit & ~bus.we_l;
   assign bus_rd = hit & ~bus.re_l;

   // External module must retry while the bus writes here
   assign wait_wr   = bus_wr;
   assign data_read = io_reg;   // Always readable by the external module

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         io_reg <= RST_VAL;   // Overrides all writes
      end else if (bus_wr) begin
         io_reg <= bus.wdata;   // Bus write wins
      end else if (reg_wr_en) begin
         io_reg <= data_wr;
      end
   end

   // Read return, one cycle after the strobe
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         rd_en <= 1'b0;
         rdata <= 8'h00;
      end else begin
         rd_en <= bus_rd;
         if (bus_rd && reg_wr_en) begin
            rdata <= data_wr;   // Forward the value being written
         end else if (bus_rd) begin
            rdata <= io_reg;
         end else begin
            rdata <= 8'h00;   // Keeps the top-level OR clean
         end
      end
   end

endmodule

// File: io_timer.sv
// IO timer: prescaled counter controlled by one register, count kept in another
`timescale 1ns/1ps
`include "io_bus_cfg.svh"

module io_timer (
   input  logic                     I_CLK,
   input  logic                     I_SYNC_RESET,
   input  io_bus_pkg::tmr_ctrl_u    ctrl,        // Control register contents
   input  logic [`IO_TMR_CNT_W-1:0] cnt_cur,     // Count register contents
   input  logic                     cnt_wait,    // Bus is writing the count register
   output logic                     cnt_wr_en,   // Write request to the count register
   output logic [`IO_TMR_CNT_W-1:0] cnt_next     // Value to write
);
   import io_bus_pkg::*;

   tmr_presc_t presc_cnt;   // Cycles since the last tick
   logic       tick;
   logic       active;

   // Timer does nothing unless counting or clearing
   assign active = ctrl.f.enable | ctrl.f.clear;

   // Tick every prescale+1 enabled cycles
   assign tick = ctrl.f.enable & (presc_cnt == ctrl.f.prescale);

   // Increment from the register value, so a bus-written count is the new start
   assign cnt_next = ctrl.f.clear ? '0 :
                     cnt_cur + {{(`IO_TMR_CNT_W-1){1'b0}}, 1'b1};

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         presc_cnt <= '0;
      end else if (!ctrl.f.enable || tick) begin
         presc_cnt <= '0;   // Restart prescale period
      end else begin
         presc_cnt <= presc_cnt + tmr_presc_t'(1);
      end
   end

   // Write request stays raised while the bus write takes the register
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         cnt_wr_en <= 1'b0;
      end else begin
         cnt_wr_en <= active & (ctrl.f.clear | tick | (cnt_wr_en & cnt_wait));
      end
   end

endmodule

// File: io_subsystem_top.sv
// IO subsystem top: arbiter, four memory-mapped registers and the timer on one IO bus
`timescale 1ns/1ps
`include "io_bus_cfg.svh"

module io_subsystem_top (
   input  logic        I_CLK,
   input  logic        I_SYNC_RESET,
   input  logic        host_req,
   input  logic        host_we,
   input  logic [15:0] host_addr,
   input  logic [7:0]  host_wdata,
   output logic        host_gnt,
   output logic        host_rvalid,
   output logic [7:0]  host_rdata,
   input  logic        debug_req,
   input  logic        debug_we,
   input  logic [15:0] debug_addr,
   input  logic [7:0]  debug_wdata,
   output logic        debug_gnt,
   output logic        debug_rvalid,
   output logic [7:0]  debug_rdata
);
   import io_bus_pkg::*;

   logic [7:0]                sc0_rdata;
   logic                      sc0_rd_en;
   logic [7:0]                sc1_rdata;
   logic                      sc1_rd_en;
   logic [7:0]                ctl_rdata;
   logic                      ctl_rd_en;
   logic [7:0]                cnt_rdata;
   logic                      cnt_rd_en;
   tmr_ctrl_u                 tmr_ctrl;      // Control byte, decoded by the timer
   logic [`IO_TMR_CNT_W-1:0]  tmr_cnt_cur;
   logic [`IO_TMR_CNT_W-1:0]  tmr_cnt_next;
   logic                      tmr_cnt_wait;
   logic                      tmr_cnt_wr_en;

   io_bus_if bus ();

   // Read return, idle registers drive zero
   assign bus.rdata = sc0_rdata | sc1_rdata | ctl_rdata | cnt_rdata;
   assign bus.rd_en = sc0_rd_en | sc1_rd_en | ctl_rd_en | cnt_rd_en;

   io_bus_arbiter u_arbiter (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .host_req     (host_req),
      .host_we      (host_we),
      .host_addr    (host_addr),
      .host_wdata   (host_wdata),
      .host_gnt     (host_gnt),
      .host_rvalid  (host_rvalid),
      .host_rdata   (host_rdata),
      .debug_req    (debug_req),
      .debug_we     (debug_we),
      .debug_addr   (debug_addr),
      .debug_wdata  (debug_wdata),
      .debug_gnt    (debug_gnt),
      .debug_rvalid (debug_rvalid),
      .debug_rdata  (debug_rdata),
      .bus          (bus.master)
   );

   // Scratch registers, no external writer
   io_bus_parser_reg #(.REG_ADDR(`IO_ADDR_SCRATCH0), .RST_VAL(`IO_RST_SCRATCH0)) u_scratch0 (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus.target),
      .data_wr (8'h00), .reg_wr_en (1'b0), .data_read (), .wait_wr (),
      .rdata (sc0_rdata), .rd_en (sc0_rd_en)
   );

   io_bus_parser_reg #(.REG_ADDR(`IO_ADDR_SCRATCH1), .RST_VAL(`IO_RST_SCRATCH1)) u_scratch1 (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus.target),
      .data_wr (8'h00), .reg_wr_en (1'b0), .data_read (), .wait_wr (),
      .rdata (sc1_rdata), .rd_en (sc1_rd_en)
   );

   // Timer control, raw byte stored here
   io_bus_parser_reg #(.REG_ADDR(`IO_ADDR_TMR_CTRL), .RST_VAL(`IO_RST_TMR_CTRL)) u_tmr_ctrl (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus.target),
      .data_wr (8'h00), .reg_wr_en (1'b0), .data_read (tmr_ctrl.raw), .wait_wr (),
      .rdata (ctl_rdata), .rd_en (ctl_rd_en)
   );

   // Timer count, written by the timer unless the bus writes
   io_bus_parser_reg #(.REG_ADDR(`IO_ADDR_TMR_CNT), .RST_VAL(`IO_RST_TMR_CNT)) u_tmr_cnt (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET), .bus (bus.target),
      .data_wr (tmr_cnt_next), .reg_wr_en (tmr_cnt_wr_en), .data_read (tmr_cnt_cur),
      .wait_wr (tmr_cnt_wait), .rdata (cnt_rdata), .rd_en (cnt_rd_en)
   );

   io_timer u_timer (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .ctrl         (tmr_ctrl),
      .cnt_cur      (tmr_cnt_cur),
      .cnt_wait     (tmr_cnt_wait),
      .cnt_wr_en    (tmr_cnt_wr_en),
      .cnt_next     (tmr_cnt_next)
   );

endmodule

// File: io_subsystem_assert.sv
// IO bus assertions: grant exclusivity, strobe exclusivity and read return latency
`timescale 1ns/1ps

module io_subsystem_assert (
   input logic I_CLK,
   input logic I_SYNC_RESET,
   input logic host_gnt,
   input logic debug_gnt,
   input logic host_rvalid,
   input logic debug_rvalid,
   input logic we_l,      // Bus write strobe, active low
   input logic re_l       // Bus read strobe, active low
);

   // One owner per bus cycle
   a_gnt_excl: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      !(host_gnt && debug_gnt))
      else $error("host_gnt and debug_gnt high in the same cycle");

   // Strobes are mutually exclusive
   a_strobe_excl: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      !(!we_l && !re_l))
      else $error("we_l and re_l low in the same cycle");

   // Read strobe goes out with the grant, data returns two cycles later
   a_host_rd_lat: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      (host_gnt && !re_l) |-> ##2 host_rvalid)
      else $error("host read grant not followed by host_rvalid two cycles later");

   a_debug_rd_lat: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      (debug_gnt && !re_l) |-> ##2 debug_rvalid)
      else $error("debug read grant not followed by debug_rvalid two cycles later");

endmodule

// Every arbiter instance gets the checks
bind io_bus_arbiter io_subsystem_assert u_assert (
   .I_CLK        (I_CLK),
   .I_SYNC_RESET (I_SYNC_RESET),
   .host_gnt     (host_gnt),
   .debug_gnt    (debug_gnt),
   .host_rvalid  (host_rvalid),
   .debug_rvalid (debug_rvalid),
   .we_l         (bus.we_l),
   .re_l         (bus.re_l)
);

// File: tb_io_subsystem.sv
// IO subsystem testbench: reset values, arbitration, read return routing and timer control
`timescale 1ns/1ps
`include "io_bus_cfg.svh"

module tb_io_subsystem;

   localparam int TIMEOUT_CYC = 20;   // Longest wait for gnt or rvalid
   localparam int MIX_LEN     = 24;   // Transactions per master in the mixed run

   logic        I_CLK;
   logic        I_SYNC_RESET;
   logic        host_req;
   logic        host_we;
   logic [15:0] host_addr;
   logic [7:0]  host_wdata;
   logic        host_gnt;
   logic        host_rvalid;
   logic [7:0]  host_rdata;
   logic        debug_req;
   logic        debug_we;
   logic [15:0] debug_addr;
   logic [7:0]  debug_wdata;
   logic        debug_gnt;
   logic        debug_rvalid;
   logic [7:0]  debug_rdata;

   logic [7:0]  scratch_mdl [2];           // Scratch0 and scratch1 as seen by the bus
   logic [8:0]  host_exp_q [$];            // {check, expected data} per host read
   logic [8:0]  debug_exp_q [$];
   logic        alt_chk;                   // Grant alternation checked while high
   logic        seen_gnt;
   logic        last_gnt_dbg;              // Owner of the most recent grant
   logic        mix_we   [2][MIX_LEN];     // Mixed run stimulus, per master
   logic        mix_sel  [2][MIX_LEN];
   logic [7:0]  mix_data [2][MIX_LEN];

   io_subsystem_top UUT (
      .I_CLK (I_CLK), .I_SYNC_RESET (I_SYNC_RESET),
      .host_req (host_req), .host_we (host_we), .host_addr (host_addr),
      .host_wdata (host_wdata), .host_gnt (host_gnt), .host_rvalid (host_rvalid),
      .host_rdata (host_rdata),
      .debug_req (debug_req), .debug_we (debug_we), .debug_addr (debug_addr),
      .debug_wdata (debug_wdata), .debug_gnt (debug_gnt), .debug_rvalid (debug_rvalid),
      .debug_rdata (debug_rdata)
   );

   always #50 I_CLK = ~I_CLK;   // 100 ns period

   // Expected bus read of a scratch register
   function automatic logic [7:0] ref_read(input logic [15:0] addr);
      if (addr == `IO_ADDR_SCRATCH1) begin
         return scratch_mdl[1];
      end
      return scratch_mdl[0];
   endfunction

   function automatic logic is_scratch(input logic [15:0] addr);
      return (addr == `IO_ADDR_SCRATCH0) || (addr == `IO_ADDR_SCRATCH1);
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_val(input string name, input logic [7:0] actual,
                            input logic [7:0] expected);
      if (actual !== expected) begin
         fail_run($sformatf("FAILED %s: got 0x%02h, expected 0x%02h", name, actual, expected));
      end
   endtask

   task automatic drive_req(input logic mst, input logic req, input logic we,
                            input logic [15:0] addr, input logic [7:0] wdata);
      if (mst) begin
         debug_req   = req;
         debug_we    = we;
         debug_addr  = addr;
         debug_wdata = wdata;
      end else begin
         host_req   = req;
         host_we    = we;
         host_addr  = addr;
         host_wdata = wdata;
      end
   endtask

   // Raise a request, hold it until gnt, then log the transaction in the model
   task automatic issue(input logic mst, input logic we, input logic [15:0] addr,
                        input logic [7:0] wdata, input logic limit_wait);
      int   n;
      int   others;   // Grants to the other master while waiting
      logic got;
      @(posedge I_CLK);
      #1;
      drive_req(mst, 1'b1, we, addr, wdata);
      n = 0;
      others = 0;
      got = 1'b0;
      while (!got) begin
         @(negedge I_CLK);
         got = mst ? debug_gnt : host_gnt;
         if (!got) begin
            n++;
            if (mst ? host_gnt : debug_gnt) others++;
            if (n >= TIMEOUT_CYC) fail_run("Timeout waiting for a bus grant");
         end
      end
      if (limit_wait && others > 1) fail_run("A request waited for more than one grant");
      if (we) begin
         if (addr == `IO_ADDR_SCRATCH0) scratch_mdl[0] = wdata;
         if (addr == `IO_ADDR_SCRATCH1) scratch_mdl[1] = wdata;
      end else if (mst) begin
         debug_exp_q.push_back(is_scratch(addr) ? {1'b1, ref_read(addr)} : 9'h000);
      end else begin
         host_exp_q.push_back(is_scratch(addr) ? {1'b1, ref_read(addr)} : 9'h000);
      end
   endtask

   task automatic release_req(input logic mst);
      @(posedge I_CLK);
      #1;
      drive_req(mst, 1'b0, 1'b0, 16'h0000, 8'h00);
   endtask

   task automatic wait_read_data(input logic mst, output logic [7:0] data);
      int   n;
      logic got;
      n = 0;
      got = 1'b0;
      while (!got) begin
         @(negedge I_CLK);
         got = mst ? debug_rvalid : host_rvalid;
         if (!got) begin
            n++;
            if (n >= TIMEOUT_CYC) fail_run("Timeout waiting for read data");
         end
      end
      data = mst ? debug_rdata : host_rdata;
   endtask

   task automatic write_reg(input logic mst, input logic [15:0] addr, input logic [7:0] data);
      issue(mst, 1'b1, addr, data, 1'b0);
      release_req(mst);
   endtask

   task automatic read_issue(input logic mst, input logic [15:0] addr);
      issue(mst, 1'b0, addr, 8'h00, 1'b0);
      release_req(mst);
   endtask

   task automatic read_reg(input logic mst, input logic [15:0] addr, output logic [7:0] data);
      read_issue(mst, addr);
      wait_read_data(mst, data);
   endtask

   task automatic drain_reads;
      int n;
      n = 0;
      while (host_exp_q.size() != 0 || debug_exp_q.size() != 0) begin
         @(negedge I_CLK);
         n++;
         if (n >= TIMEOUT_CYC) fail_run("Timeout waiting for outstanding reads");
      end
   endtask

   task automatic run_mix(input logic mst);
      logic [15:0] addr;
      for (int i = 0; i < MIX_LEN; i++) begin
         addr = mix_sel[mst][i] ? `IO_ADDR_SCRATCH1 : `IO_ADDR_SCRATCH0;
         issue(mst, mix_we[mst][i], addr, mix_data[mst][i], 1'b1);
      end
      release_req(mst);
   endtask

   // Compare process, outputs sampled mid-cycle
   always @(negedge I_CLK) begin
      logic [8:0] ent;
      if (host_rvalid) begin
         if (host_exp_q.size() == 0) fail_run("Host rvalid with no read outstanding");
         ent = host_exp_q.pop_front();
         if (ent[8]) check_val("host_rdata", host_rdata, ent[7:0]);
      end
      if (debug_rvalid) begin
         if (debug_exp_q.size() == 0) fail_run("Debug rvalid with no read outstanding");
         ent = debug_exp_q.pop_front();
         if (ent[8]) check_val("debug_rdata", debug_rdata, ent[7:0]);
      end
      if (host_gnt || debug_gnt) begin
         if (alt_chk && seen_gnt && debug_gnt == last_gnt_dbg) begin
            fail_run("Grants did not alternate");
         end
         seen_gnt     = 1'b1;
         last_gnt_dbg = debug_gnt;   // Kept across tests, so the first tie is judged too
      end
   end

   initial begin
      logic [7:0] rd_a;
      logic [7:0] rd_b;
      logic [7:0] wval;
      void'($urandom(49));
      I_CLK = 1'b0;
      I_SYNC_RESET = 1'b1;
      drive_req(1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
      drive_req(1'b1, 1'b0, 1'b0, 16'h0000, 8'h00);
      scratch_mdl[0] = `IO_RST_SCRATCH0;
      scratch_mdl[1] = `IO_RST_SCRATCH1;
      alt_chk = 1'b0;
      seen_gnt = 1'b0;
      repeat (16) @(posedge I_CLK);
      #1;
      I_SYNC_RESET = 1'b0;

      // Reset values
      read_reg(1'b0, `IO_ADDR_SCRATCH0, rd_a);
      check_val("host_rdata", rd_a, `IO_RST_SCRATCH0);
      read_reg(1'b0, `IO_ADDR_SCRATCH1, rd_a);
      check_val("host_rdata", rd_a, 8'hA5);
      read_reg(1'b0, `IO_ADDR_TMR_CTRL, rd_a);
      check_val("host_rdata", rd_a, `IO_RST_TMR_CTRL);

      // Host write then read back, alternating scratch registers
      for (int i = 0; i < 8; i++) begin
         wval = 8'($urandom());
         write_reg(1'b0, i[0] ? `IO_ADDR_SCRATCH1 : `IO_ADDR_SCRATCH0, wval);
         read_reg(1'b0, i[0] ? `IO_ADDR_SCRATCH1 : `IO_ADDR_SCRATCH0, rd_a);
         check_val("host_rdata", rd_a, ref_read(i[0] ? `IO_ADDR_SCRATCH1 : `IO_ADDR_SCRATCH0));
      end

      // Both masters busy every cycle, stimulus drawn up front
      for (int i = 0; i < MIX_LEN; i++) begin
         for (int m = 0; m < 2; m++) begin
            mix_we[m][i]   = 1'($urandom());
            mix_sel[m][i]  = 1'($urandom());
            mix_data[m][i] = 8'($urandom());
         end
      end
      drain_reads();
      alt_chk = 1'b1;
      fork
         run_mix(1'b0);
         run_mix(1'b1);
      join
      alt_chk = 1'b0;
      drain_reads();

      // Two reads in flight, one per port
      wval = 8'($urandom());
      write_reg(1'b0, `IO_ADDR_SCRATCH0, wval);
      write_reg(1'b1, `IO_ADDR_SCRATCH1, ~wval);
      fork
         read_issue(1'b0, `IO_ADDR_SCRATCH0);
         read_issue(1'b1, `IO_ADDR_SCRATCH1);
      join
      drain_reads();

      // Timer disabled holds, bus write overrides, enable advances
      read_reg(1'b0, `IO_ADDR_TMR_CNT, rd_a);
      read_reg(1'b0, `IO_ADDR_TMR_CNT, rd_b);
      check_val("host_rdata", rd_b, rd_a);
      wval = 8'($urandom());
      write_reg(1'b0, `IO_ADDR_TMR_CNT, wval);
      read_reg(1'b0, `IO_ADDR_TMR_CNT, rd_a);
      check_val("host_rdata", rd_a, wval);
      write_reg(1'b0, `IO_ADDR_TMR_CTRL, 8'h80);   // Enable, tick every cycle
      repeat (6) @(posedge I_CLK);
      write_reg(1'b0, `IO_ADDR_TMR_CTRL, 8'h00);
      repeat (4) @(posedge I_CLK);
      read_reg(1'b0, `IO_ADDR_TMR_CNT, rd_a);
      if (rd_a == wval) fail_run("Timer count did not advance while enabled");
      read_reg(1'b0, `IO_ADDR_TMR_CNT, rd_b);
      check_val("host_rdata", rd_b, rd_a);

      // Clear with enable low
      write_reg(1'b0, `IO_ADDR_TMR_CTRL, 8'h40);
      read_reg(1'b0, `IO_ADDR_TMR_CNT, rd_a);
      check_val("host_rdata", rd_a, 8'h00);
      write_reg(1'b0, `IO_ADDR_TMR_CTRL, 8'h00);
      drain_reads();

      $display("All tests passed!");
      $finish;
   end

endmodule

// File: io_subsystem.f
+incdir+.
io_bus_pkg.sv
io_bus_if.sv
io_bus_arbiter.sv
io_bus_parser_reg.sv
io_timer.sv
io_subsystem_top.sv
io_subsystem_assert.sv
tb_io_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the IO subsystem testbench with Verilator

TOP=tb_io_subsystem
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$TOP" -f io_subsystem.f
if [ $? -ne 0 ]; then
   echo "RESULT: FAIL (build error)"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

# The log decides first, the exit status catches assertion stops
if grep -q "Test failures found" "$LOG"; then
   echo "RESULT: FAIL"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "RESULT: FAIL (simulator exit status $status)"
   exit 1
fi

if ! grep -q "All tests passed!" "$LOG"; then
   echo "RESULT: FAIL (run ended without a result)"
   exit 1
fi

echo "RESULT: PASS"
exit 0
